// ==== Makefile ====
# Verilator build and run of the UMI endpoint testbench

VERILATOR ?= verilator
TOP       ?= umi_tb
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --assert -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Test completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/umi_arbiter.sv ====
/*
 * two port round-robin arbiter onto one memory bus
 * owner forwarded combinationally, handed over on the done edge
 */
`timescale 1ns/1ps

module umi_arbiter (
   input  logic         clk,
   input  logic         rst_n,
   umi_req_if.completer up0,
   umi_req_if.completer up1,
   umi_req_if.requester down
);

   logic busy_q;
   logic owner_q;    // current owner, and last winner once idle
   logic release_b;  // owner finishes this cycle
   logic free;       // an owner may be chosen on the next edge
   logic want0;
   logic want1;

   assign release_b = busy_q & down.done;
   assign free      = ~busy_q | release_b;

   // the finishing owner still shows valid, mask it out
   assign want0 = up0.valid & ~(release_b & ~owner_q);
   assign want1 = up1.valid & ~(release_b & owner_q);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q  <= 1'b0;
         owner_q <= 1'b1;   // port 0 wins the first tie
      end else if (free) begin
         busy_q <= want0 | want1;
         if (want0 & want1) begin
            owner_q <= ~owner_q;   // loser of last round goes
         end else if (want0) begin
            owner_q <= 1'b0;
         end else if (want1) begin
            owner_q <= 1'b1;
         end
      end
   end

   // forward the owner
   assign down.valid     = busy_q & (owner_q ? up1.valid : up0.valid);
   assign down.is_read   = owner_q ? up1.is_read   : up0.is_read;
   assign down.is_atomic = owner_q ? up1.is_atomic : up0.is_atomic;
   assign down.atomic_op = owner_q ? up1.atomic_op : up0.atomic_op;
   assign down.addr      = owner_q ? up1.addr      : up0.addr;
   assign down.wdata     = owner_q ? up1.wdata     : up0.wdata;

   // completion only reaches the owner
   assign up0.done  = busy_q & ~owner_q & down.done;
   assign up1.done  = busy_q & owner_q & down.done;
   assign up0.rdata = owner_q ? '0 : down.rdata;
   assign up1.rdata = owner_q ? down.rdata : '0;

endmodule

// ==== source/umi_decode.sv ====
/*
 * UMI command decoder
 * splits a command word into its access class, write-ack flag,
 * atomic operation and raw fields
 */
`timescale 1ns/1ps

module umi_decode (
   input  umi_pkg::umi_cmd_t cmd,
   output logic              cmd_invalid,    // all-zero opcode
   output logic              cmd_read,       // plain read or atomic
   output logic              cmd_write,
   output logic              cmd_atomic,
   output logic              cmd_write_ack,
   output logic [2:0]        cmd_atomic_op,
   output logic [3:0]        cmd_size,
   output logic [19:0]       cmd_user
);

   import umi_pkg::*;

   logic read_bit;   // opcode bit 3

   assign read_bit = |(cmd.f.opcode & umi_op_read);

   assign cmd_invalid = ~|cmd.f.opcode;
   assign cmd_read    = read_bit & ~cmd_invalid;
   assign cmd_write   = ~read_bit & ~cmd_invalid;

   // atomics are reads with the 1001 low nibble
   assign cmd_atomic    = cmd.at.op_low == umi_op_atomic_low;
   assign cmd_atomic_op = cmd.at.atomic_op;   // only meaningful with cmd_atomic

   // ack is the one write kind that wants a response
   assign cmd_write_ack = cmd_write & (cmd.wr.write_kind == umi_wr_ack);

   assign cmd_size = cmd.f.size;
   assign cmd_user = cmd.f.user;

endmodule

// ==== source/umi_endpoint.sv ====
/*
 * UMI memory endpoint top level
 * two requester ports share one word memory through a round-robin arbiter
 */
`timescale 1ns/1ps

module umi_endpoint #(
   parameter int aw = umi_pkg::umi_default_aw,
   parameter int dw = umi_pkg::umi_default_dw
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          req_valid_0,
   input  logic [31:0]   req_cmd_0,
   input  logic [aw-1:0] req_addr_0,
   input  logic [dw-1:0] req_wdata_0,
   output logic          rsp_valid_0,
   output logic          rsp_error_0,
   output logic [dw-1:0] rsp_rdata_0,
   input  logic          req_valid_1,
   input  logic [31:0]   req_cmd_1,
   input  logic [aw-1:0] req_addr_1,
   input  logic [dw-1:0] req_wdata_1,
   output logic          rsp_valid_1,
   output logic          rsp_error_1,
   output logic [dw-1:0] rsp_rdata_1
);

   umi_req_if #(.aw(aw), .dw(dw)) port0_bus ();
   umi_req_if #(.aw(aw), .dw(dw)) port1_bus ();
   umi_req_if #(.aw(aw), .dw(dw)) mem_bus ();

   umi_port #(.aw(aw), .dw(dw)) u_port0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid_0),
      .req_cmd   (req_cmd_0),
      .req_addr  (req_addr_0),
      .req_wdata (req_wdata_0),
      .rsp_valid (rsp_valid_0),
      .rsp_error (rsp_error_0),
      .rsp_rdata (rsp_rdata_0),
      .bus       (port0_bus)
   );

   umi_port #(.aw(aw), .dw(dw)) u_port1 (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid_1),
      .req_cmd   (req_cmd_1),
      .req_addr  (req_addr_1),
      .req_wdata (req_wdata_1),
      .rsp_valid (rsp_valid_1),
      .rsp_error (rsp_error_1),
      .rsp_rdata (rsp_rdata_1),
      .bus       (port1_bus)
   );

   umi_arbiter u_arbiter (
      .clk   (clk),
      .rst_n (rst_n),
      .up0   (port0_bus),
      .up1   (port1_bus),
      .down  (mem_bus)
   );

   umi_mem #(.aw(aw), .dw(dw)) u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mem_bus)
   );

endmodule

// ==== source/umi_mem.sv ====
/*
 * flop based word memory
 * plain reads and writes plus atomic read-modify-write,
 * done strobes one cycle after valid
 */
`timescale 1ns/1ps

module umi_mem #(
   parameter int aw = umi_pkg::umi_default_aw,
   parameter int dw = umi_pkg::umi_default_dw
) (
   input  logic         clk,
   input  logic         rst_n,
   umi_req_if.completer bus
);

   import umi_pkg::*;

   localparam int depth = 2 ** aw;

   logic [dw-1:0] mem_q [depth];
   logic [dw-1:0] old_word;      // word at the request address
   logic [dw-1:0] amo_result;
   logic [dw-1:0] store_data;
   logic [dw-1:0] rdata_q;
   logic          done_q;
   logic          access;        // first cycle of a request
   logic          store;

   assign old_word = mem_q[bus.addr];
   assign access   = bus.valid & ~done_q;   // done cycle never repeats the access
   assign store    = access & (bus.is_atomic | ~bus.is_read);

   always_comb begin
      case (bus.atomic_op)
         umi_at_swap: amo_result = bus.wdata;
         umi_at_add:  amo_result = old_word + bus.wdata;
         umi_at_and:  amo_result = old_word & bus.wdata;
         umi_at_or:   amo_result = old_word | bus.wdata;
         umi_at_xor:  amo_result = old_word ^ bus.wdata;
         umi_at_max: begin
            amo_result = ($signed(old_word) > $signed(bus.wdata)) ? old_word : bus.wdata;
         end
         umi_at_min: begin
            amo_result = ($signed(old_word) < $signed(bus.wdata)) ? old_word : bus.wdata;
         end
         default:     amo_result = old_word;   // 111, word kept
      endcase
   end

   assign store_data = bus.is_atomic ? amo_result : bus.wdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         done_q <= 1'b0;
         for (int i = 0; i < depth; i++) begin
            mem_q[i] <= '0;   // memory reads zero after reset
         end
      end else begin
         done_q <= access;
         if (store) begin
            mem_q[bus.addr] <= store_data;
         end
      end
   end

   // old word goes back for reads and atomics
   always_ff @(posedge clk) begin
      if (access) begin
         rdata_q <= old_word;
      end
   end

   assign bus.done  = done_q;
   assign bus.rdata = rdata_q;

endmodule

// ==== source/umi_pkg.sv ====
/*
 * UMI endpoint shared definitions
 * command word layout with write and atomic views of the opcode byte,
 * opcode codes and default address and data widths
 */
package umi_pkg;

   localparam int umi_default_aw = 6;   // 64 words
   localparam int umi_default_dw = 32;

   // plain field view of the command word
   typedef struct packed {
      logic [19:0] user;
      logic [3:0]  size;    // burst length, ignored here
      logic [7:0]  opcode;
   } umi_cmd_fields_t;

   // write view, kind in the low three opcode bits
   typedef struct packed {
      logic [19:0] user;
      logic [3:0]  size;
      logic [4:0]  rsvd;
      logic [2:0]  write_kind;
   } umi_cmd_write_t;

   // atomic view, operation above the 1001 low nibble
   typedef struct packed {
      logic [19:0] user;
      logic [3:0]  size;
      logic        rsvd;
      logic [2:0]  atomic_op;
      logic [3:0]  op_low;
   } umi_cmd_atomic_t;

   typedef union packed {
      umi_cmd_fields_t f;
      umi_cmd_write_t  wr;
      umi_cmd_atomic_t at;
   } umi_cmd_t;

   localparam logic [7:0] umi_op_read       = 8'h08;   // bit 3 marks a read
   localparam logic [3:0] umi_op_atomic_low = 4'b1001;

   // write kinds
   localparam logic [2:0] umi_wr_normal   = 3'b001;
   localparam logic [2:0] umi_wr_response = 3'b010;
   localparam logic [2:0] umi_wr_signal   = 3'b011;
   localparam logic [2:0] umi_wr_stream   = 3'b100;
   localparam logic [2:0] umi_wr_ack      = 3'b101;
   localparam logic [2:0] umi_wr_user1    = 3'b110;
   localparam logic [2:0] umi_wr_user2    = 3'b111;

   // atomic operations, 111 left unused
   localparam logic [2:0] umi_at_swap = 3'b000;
   localparam logic [2:0] umi_at_add  = 3'b001;
   localparam logic [2:0] umi_at_and  = 3'b010;
   localparam logic [2:0] umi_at_or   = 3'b011;
   localparam logic [2:0] umi_at_xor  = 3'b100;
   localparam logic [2:0] umi_at_max  = 3'b101;   // signed
   localparam logic [2:0] umi_at_min  = 3'b110;   // signed

endpackage

// ==== source/umi_port.sv ====
/*
 * UMI requester port
 * captures one strobed command, holds it on the memory request bus
 * until done and returns the response strobe, or an error strobe
 * for an invalid opcode
 */
`timescale 1ns/1ps

module umi_port #(
   parameter int aw = umi_pkg::umi_default_aw,
   parameter int dw = umi_pkg::umi_default_dw
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req_valid,
   input  umi_pkg::umi_cmd_t req_cmd,
   input  logic [aw-1:0]     req_addr,
   input  logic [dw-1:0]     req_wdata,
   output logic              rsp_valid,
   output logic              rsp_error,
   output logic [dw-1:0]     rsp_rdata,
   umi_req_if.requester      bus
);

   logic          dec_invalid;
   logic          dec_read;
   logic          dec_write;
   logic          dec_atomic;
   logic          dec_write_ack;
   logic [2:0]    dec_atomic_op;
   logic          accept;        // strobe taken this edge
   logic          busy_q;
   logic          read_q;        // also set for atomics
   logic          atomic_q;
   logic          ack_q;
   logic [2:0]    atomic_op_q;
   logic [aw-1:0] addr_q;
   logic [dw-1:0] wdata_q;

   umi_decode u_decode (
      .cmd           (req_cmd),
      .cmd_invalid   (dec_invalid),
      .cmd_read      (dec_read),
      .cmd_write     (dec_write),
      .cmd_atomic    (dec_atomic),
      .cmd_write_ack (dec_write_ack),
      .cmd_atomic_op (dec_atomic_op),
      .cmd_size      (),
      .cmd_user      ()
   );

   // strobes on a busy port are dropped
   assign accept = req_valid & ~busy_q & (dec_read | dec_write);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q    <= 1'b0;
         rsp_valid <= 1'b0;
         rsp_error <= 1'b0;
      end else begin
         rsp_error <= req_valid & ~busy_q & dec_invalid;   // no memory access
         rsp_valid <= bus.done & (read_q | ack_q);         // silent writes stay quiet
         if (accept) begin
            busy_q <= 1'b1;
         end else if (bus.done) begin
            busy_q <= 1'b0;
         end
      end
   end

   // held command and response data
   always_ff @(posedge clk) begin
      if (accept) begin
         read_q      <= dec_read;
         atomic_q    <= dec_atomic;
         ack_q       <= dec_write_ack;
         atomic_op_q <= dec_atomic_op;
         addr_q      <= req_addr;
         wdata_q     <= req_wdata;
      end
      if (bus.done) begin
         rsp_rdata <= read_q ? bus.rdata : '0;   // write-ack returns zero
      end
   end

   assign bus.valid     = busy_q;
   assign bus.is_read   = read_q;
   assign bus.is_atomic = atomic_q;
   assign bus.atomic_op = atomic_op_q;
   assign bus.addr      = addr_q;
   assign bus.wdata     = wdata_q;

endmodule

// ==== source/umi_req_if.sv ====
/*
 * single word memory access request with its completion
 * done strobes one cycle after the completer first sees valid
 */
`timescale 1ns/1ps

interface umi_req_if #(
   parameter int aw = umi_pkg::umi_default_aw,
   parameter int dw = umi_pkg::umi_default_dw
);

   logic          valid;       // held until done
   logic          is_read;     // set for reads and atomics
   logic          is_atomic;
   logic [2:0]    atomic_op;
   logic [aw-1:0] addr;
   logic [dw-1:0] wdata;
   logic          done;        // one cycle strobe
   logic [dw-1:0] rdata;      // old word, valid with done

   modport requester (
      output valid, is_read, is_atomic, atomic_op, addr, wdata,
      input  done, rdata
   );

   modport completer (
      input  valid, is_read, is_atomic, atomic_op, addr, wdata,
      output done, rdata
   );

endinterface

// ==== test/umi_tb.sv ====
/*
 * UMI endpoint testbench
 * random single and two-port traffic from an LFSR,
 * responses and final memory checked against a word model
 */
`timescale 1ns/1ps

module umi_tb;

   import umi_pkg::*;

   localparam int aw = umi_default_aw;
   localparam int dw = umi_default_dw;
   localparam int depth = 2 ** aw;
   localparam int kind_none = 0;   // expected response kinds
   localparam int kind_rsp  = 1;
   localparam int kind_err  = 2;

   typedef logic [aw-1:0] addr_t;
   typedef logic [dw-1:0] data_t;

   logic     clk;
   logic     rst_n;
   logic     req_valid [2];
   umi_cmd_t req_cmd [2];
   addr_t    req_addr [2];
   data_t    req_wdata [2];
   logic     rsp_valid [2];
   logic     rsp_error [2];
   data_t    rsp_rdata [2];

   logic [31:0] lfsr;
   data_t       model_mem [depth];   // expected memory contents
   logic        stage_en [2];        // staged request per port
   umi_cmd_t    stage_cmd [2];
   addr_t       stage_addr [2];
   data_t       stage_wdata [2];
   int          exp_kind [2];
   data_t       exp_data [2];
   logic [1:0]  got;
   logic [1:0]  want;
   int          errors;
   int          errors_at_start;
   int          pass_count;
   int          fail_count;
   string       test_name;

   umi_endpoint #(.aw(aw), .dw(dw)) DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid_0 (req_valid[0]),
      .req_cmd_0   (req_cmd[0]),
      .req_addr_0  (req_addr[0]),
      .req_wdata_0 (req_wdata[0]),
      .rsp_valid_0 (rsp_valid[0]),
      .rsp_error_0 (rsp_error[0]),
      .rsp_rdata_0 (rsp_rdata[0]),
      .req_valid_1 (req_valid[1]),
      .req_cmd_1   (req_cmd[1]),
      .req_addr_1  (req_addr[1]),
      .req_wdata_1 (req_wdata[1]),
      .rsp_valid_1 (rsp_valid[1]),
      .rsp_error_1 (rsp_error[1]),
      .rsp_rdata_1 (rsp_rdata[1])
   );

   always #50 clk = ~clk;   // 100 ns period

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++) begin
         fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr  = {lfsr[30:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   function automatic umi_cmd_t make_cmd(input logic [7:0] opcode);
      umi_cmd_t c;
      c.f.user   = 20'(next_bits(20));   // ignored by the endpoint
      c.f.size   = 4'(next_bits(4));
      c.f.opcode = opcode;
      return c;
   endfunction

   function automatic umi_cmd_t make_write(input logic [2:0] kind);
      umi_cmd_t c;
      c = make_cmd(8'h00);
      c.wr.rsvd       = '0;   // bit 3 clear, so a write
      c.wr.write_kind = kind;
      return c;
   endfunction

   function automatic umi_cmd_t make_atomic(input logic [2:0] op);
      umi_cmd_t c;
      c = make_cmd(8'h00);
      c.at.rsvd      = 1'b0;
      c.at.atomic_op = op;
      c.at.op_low    = umi_op_atomic_low;
      return c;
   endfunction

   function automatic logic [2:0] random_kind();
      logic [2:0] k;
      k = 3'(next_bits(3));
      if (k == 3'b000) begin
         k = umi_wr_normal;   // zero would be invalid
      end
      return k;
   endfunction

   // new word for an atomic, signed compare for max and min
   function automatic data_t atomic_result(input logic [2:0] op, input data_t old,
                                           input data_t w);
      case (op)
         umi_at_swap: return w;
         umi_at_add:  return old + w;
         umi_at_and:  return old & w;
         umi_at_or:   return old | w;
         umi_at_xor:  return old ^ w;
         umi_at_max:  return ($signed(w) > $signed(old)) ? w : old;
         umi_at_min:  return ($signed(w) < $signed(old)) ? w : old;
         default:     return old;   // 111 leaves the word
      endcase
   endfunction

   // expected response and model update for one staged request
   task automatic model_access(input int p);
      umi_cmd_t c;
      data_t    old;
      c   = stage_cmd[p];
      old = model_mem[stage_addr[p]];
      if (c.f.opcode == 8'h00) begin
         exp_kind[p] = kind_err;   // memory untouched
      end else if (c.f.opcode[3]) begin
         exp_kind[p] = kind_rsp;
         exp_data[p] = old;
         if (c.at.op_low == umi_op_atomic_low) begin
            model_mem[stage_addr[p]] = atomic_result(c.at.atomic_op, old, stage_wdata[p]);
         end
      end else begin
         model_mem[stage_addr[p]] = stage_wdata[p];
         if (c.wr.write_kind == umi_wr_ack) begin
            exp_kind[p] = kind_rsp;
            exp_data[p] = '0;
         end
      end
   endtask

   task automatic set_req(input int p, input umi_cmd_t c, input addr_t a, input data_t w);
      stage_en[p]    = 1'b1;
      stage_cmd[p]   = c;
      stage_addr[p]  = a;
      stage_wdata[p] = w;
   endtask

   task automatic check_strobe(input int p);
      if (rsp_error[p]) begin
         assert (exp_kind[p] == kind_err && !got[p]) else begin
            $display("%s: unexpected error strobe on port %0d", test_name, p);
            errors++;
         end
         got[p] = 1'b1;
      end
      if (rsp_valid[p]) begin
         assert (exp_kind[p] == kind_rsp && !got[p]) else begin
            $display("%s: unexpected response strobe on port %0d", test_name, p);
            errors++;
         end
         assert (rsp_rdata[p] == exp_data[p]) else begin
            $display("CHECK FAILED %s port %0d: expected %h, actual %h",
                     test_name, p, exp_data[p], rsp_rdata[p]);
            errors++;
         end
         got[p] = 1'b1;
      end
   endtask

   // issue all staged requests together, wait for their strobes
   task automatic run_access();
      for (int p = 0; p < 2; p++) begin
         exp_kind[p] = kind_none;
         if (stage_en[p]) begin
            model_access(p);
         end
         want[p]      = exp_kind[p] != kind_none;
         req_valid[p] = stage_en[p];
         req_cmd[p]   = stage_cmd[p];
         req_addr[p]  = stage_addr[p];
         req_wdata[p] = stage_wdata[p];
      end
      got = 2'b00;
      @(negedge clk);
      for (int p = 0; p < 2; p++) begin
         req_valid[p] = 1'b0;   // single cycle strobe
         stage_en[p]  = 1'b0;
      end
      for (int cyc = 1; cyc <= 20; cyc++) begin
         check_strobe(0);
         check_strobe(1);
         if (cyc >= 6 && got == want) begin
            break;   // silent writes also done by now
         end
         @(negedge clk);
      end
      for (int p = 0; p < 2; p++) begin
         assert (got[p] || !want[p]) else begin
            $display("%s: timeout, no response on port %0d in 20 cycles", test_name, p);
            errors++;
         end
      end
   endtask

   task automatic single(input int p, input umi_cmd_t c, input addr_t a, input data_t w);
      set_req(p, c, a, w);
      run_access();
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         pass_count++;
         $display("test %s passed", test_name);
      end else begin
         fail_count++;
         $display("test %s failed", test_name);
      end
   endtask

   // both ports at once over a small address window
   task automatic two_port_test();
      logic     touched [depth];
      umi_cmd_t c [2];
      addr_t    a [2];
      logic [1:0] sel;
      for (int i = 0; i < depth; i++) begin
         touched[i] = 1'b0;
      end
      for (int r = 0; r < 40; r++) begin
         for (int p = 0; p < 2; p++) begin
            a[p] = addr_t'(next_bits(3));   // 8 words, lots of overlap
            sel  = 2'(next_bits(2));
            case (sel)
               2'd0:    c[p] = make_cmd(umi_op_read);
               2'd1:    c[p] = make_write(random_kind());
               2'd2:    c[p] = make_atomic(3'(next_bits(3)));
               default: c[p] = make_cmd(8'h00);   // invalid
            endcase
         end
         if (a[0] == a[1]) begin
            c[0] = make_cmd(umi_op_read);   // same word, keep it order free
            c[1] = make_cmd(umi_op_read);
         end
         for (int p = 0; p < 2; p++) begin
            set_req(p, c[p], a[p], data_t'(next_bits(dw)));
            touched[a[p]] = 1'b1;
         end
         run_access();
      end
      for (int i = 0; i < depth; i++) begin
         if (touched[i]) begin
            single(0, make_cmd(umi_op_read), addr_t'(i), '0);
         end
      end
   endtask

   initial begin
      addr_t a;
      data_t d;
      data_t w;
      lfsr       = 32'h1752_5685;
      clk        = 1'b0;
      rst_n      = 1'b0;
      errors     = 0;
      pass_count = 0;
      fail_count = 0;
      for (int p = 0; p < 2; p++) begin
         req_valid[p] = 1'b0;
         req_cmd[p]   = '0;
         req_addr[p]  = '0;
         req_wdata[p] = '0;
         stage_en[p]  = 1'b0;
      end
      for (int i = 0; i < depth; i++) begin
         model_mem[i] = '0;
      end
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      start_test("reset_zero");
      for (int i = 0; i < 8; i++) begin
         single(i % 2, make_cmd(umi_op_read), addr_t'(next_bits(aw)), '0);
      end
      end_test();

      start_test("write_read");
      for (int i = 0; i < 16; i++) begin
         a = addr_t'(next_bits(aw));
         single(0, make_write(random_kind()), a, data_t'(next_bits(dw)));
         single(0, make_cmd(umi_op_read), a, '0);
      end
      end_test();

      start_test("write_response");   // only ack answers, with zero
      for (int k = 1; k < 8; k++) begin
         a = addr_t'(next_bits(aw));
         d = data_t'(next_bits(dw)) | data_t'(1);   // nonzero old word
         single(1, make_write(umi_wr_normal), a, d);
         single(1, make_write(3'(k)), a, data_t'(next_bits(dw)));
         single(1, make_cmd(umi_op_read), a, '0);
      end
      end_test();

      start_test("atomics");
      for (int i = 0; i < 16; i++) begin
         a = addr_t'(next_bits(aw));
         d = data_t'(next_bits(dw));
         w = data_t'(next_bits(dw));
         if (i >= 8) begin
            w[dw-1] = ~d[dw-1];   // mixed signs for max and min
         end
         single(i % 2, make_write(umi_wr_normal), a, d);
         single(i % 2, make_atomic(3'(i % 8)), a, w);
         single(i % 2, make_cmd(umi_op_read), a, '0);
      end
      end_test();

      start_test("invalid_opcode");
      for (int i = 0; i < 4; i++) begin
         a = addr_t'(next_bits(aw));
         single(i % 2, make_write(umi_wr_normal), a, data_t'(next_bits(dw)));
         single(i % 2, make_cmd(8'h00), a, data_t'(next_bits(dw)));
         single(i % 2, make_cmd(umi_op_read), a, '0);
      end
      end_test();

      start_test("two_port");
      two_port_test();
      end_test();

      $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
source/umi_pkg.sv
source/umi_req_if.sv
source/umi_decode.sv
source/umi_port.sv
source/umi_arbiter.sv
source/umi_mem.sv
source/umi_endpoint.sv
test/umi_tb.sv
